//--- logic/fm_pkg.sv
//****************************************
// shared sizes of the fm register side
// register map and readback window
//****************************************
package fm_pkg;

    // slot geometry
    localparam int num_ch   = 6;
    localparam int num_op   = 4;
    localparam int num_slot = num_ch * num_op;  // 24 slots per rotation
    localparam int ch_w     = 3;
    localparam int op_w     = 2;
    localparam int slot_w   = 5;                // enough for 0..23

    // field widths
    localparam int fnum_w   = 11;
    localparam int block_w  = 3;
    localparam int mul_w    = 4;
    localparam int tl_w     = 7;
    localparam int phase_w  = 21;   // 17-bit shifted fnum times a 4-bit multiplier

    // host bus
    localparam int axi_addr_w = 10;
    localparam int axi_data_w = 32;

    // register numbers, ym style
    localparam logic [7:0] reg_mul     = 8'h30;   // per operator
    localparam logic [7:0] reg_tl      = 8'h40;   // per operator
    localparam logic [7:0] reg_fnum_lo = 8'hA0;   // commits the latched high part
    localparam logic [7:0] reg_fnum_hi = 8'hA4;   // latched only
    localparam logic [7:0] reg_fb_alg  = 8'hB0;
    localparam logic [7:0] reg_pan_pms = 8'hB4;

    // reads at rd_base + 4*ch give the packed channel word
    localparam logic [axi_addr_w-1:0] rd_base = 10'h200;

endpackage

//--- logic/fm_host_port.sv
//****************************************
// axi4-lite slave, byte write strobes
// and channel readback
//****************************************
`timescale 1ns/1ns

module fm_host_port (
    input  logic                          clk,
    input  logic                          rst,
    // write address / data / response
    input  logic [fm_pkg::axi_addr_w-1:0] awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [fm_pkg::axi_data_w-1:0] wdata,
    input  logic [3:0]                    wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    // read address / data
    input  logic [fm_pkg::axi_addr_w-1:0] araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [fm_pkg::axi_data_w-1:0] rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,
    // toward the decoder and channel bank
    output logic                          wr_stb,
    output logic [8:0]                    wr_addr,
    output logic [7:0]                    wr_data,
    output logic [fm_pkg::ch_w-1:0]       rd_ch,
    input  logic [fm_pkg::axi_data_w-1:0] rd_word
);
    import fm_pkg::*;

    logic                  wr_go;    // write handshake this cycle
    logic                  rd_go;    // read handshake this cycle
    logic [axi_addr_w-1:0] rd_off;
    logic                  rd_hit;

    // address and data are taken together, never while a response is pending
    assign awready = awvalid && wvalid && !bvalid;
    assign wready  = awready;
    assign wr_go   = awvalid && awready && wvalid && wready;
    assign arready = !rvalid;
    assign rd_go   = arvalid && arready;
    assign bresp   = 2'b00;  // always OKAY
    assign rresp   = 2'b00;

    // readback window, one word per channel
    assign rd_off = araddr - rd_base;
    assign rd_hit = (rd_off[1:0] == 2'd0) && (rd_off[axi_addr_w-1:2] < num_ch);
    assign rd_ch  = rd_off[2 +: ch_w];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid <= 1'b0;
            wr_stb <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            // low byte lane only, and nothing above the 9-bit register space
            wr_stb <= wr_go && wstrb[0] && !awaddr[9];
            if (wr_go)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            if (rd_go)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            wr_addr <= awaddr[8:0];
            wr_data <= wdata[7:0];
        end
        if (rd_go)
            rdata <= rd_hit ? rd_word : '0;  // zero outside the window
    end

    // a response only follows an accepted write
    assert property (@(posedge clk) disable iff (rst)
        $rose(bvalid) |-> $past(wr_go));

    // read data held until the host takes it
    assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid);

endmodule

//--- logic/fm_reg_decode.sv
//****************************************
// register number decoder, fnum latch
// and update strobes for both banks
//****************************************
`timescale 1ns/1ns

module fm_reg_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_stb,
    input  logic [8:0]              wr_addr,   // bit 8 is the part bit
    input  logic [7:0]              wr_data,
    output logic [7:0]              din,
    output logic [fm_pkg::ch_w-1:0] up_ch,
    output logic [5:0]              latch_fnum, // {block, fnum[10:8]}
    output logic                    up_fnumlo,
    output logic                    up_alg,
    output logic                    up_pms,
    output logic [fm_pkg::ch_w-1:0] up_op_ch,
    output logic [fm_pkg::op_w-1:0] up_op,
    output logic                    up_mul,
    output logic                    up_tl
);
    import fm_pkg::*;

    logic [7:0]      reg_num;
    logic [ch_w-1:0] dec_ch;
    logic            ch_ok;
    logic            hit;       // write with a usable channel field

    assign reg_num = wr_addr[7:0];
    // part 1 channels are 3..5
    assign dec_ch  = ch_w'(reg_num[1:0]) + (wr_addr[8] ? ch_w'(3) : ch_w'(0));
    assign ch_ok   = reg_num[1:0] != 2'd3;
    assign hit     = wr_stb && ch_ok;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            up_fnumlo  <= 1'b0;
            up_alg     <= 1'b0;
            up_pms     <= 1'b0;
            up_mul     <= 1'b0;
            up_tl      <= 1'b0;
            latch_fnum <= '0;
        end else begin
            // channel registers match on bits 7..2, operators on 7..4
            up_fnumlo <= hit && reg_num[7:2] == reg_fnum_lo[7:2];
            up_alg    <= hit && reg_num[7:2] == reg_fb_alg[7:2];
            up_pms    <= hit && reg_num[7:2] == reg_pan_pms[7:2];
            up_mul    <= hit && reg_num[7:4] == reg_mul[7:4];
            up_tl     <= hit && reg_num[7:4] == reg_tl[7:4];
            if (hit && reg_num[7:2] == reg_fnum_hi[7:2])
                latch_fnum <= wr_data[5:0];  // waits for the next low byte
        end
    end

    // indices and data ride along with the strobes
    always_ff @(posedge clk) begin
        if (wr_stb) begin
            din      <= wr_data;
            up_ch    <= dec_ch;
            up_op_ch <= dec_ch;
            up_op    <= reg_num[3:2];
        end
    end

    // each write touches one register at most
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({up_fnumlo, up_alg, up_pms, up_mul, up_tl}));

endmodule

//--- logic/fm_slot_seq.sv
//****************************************
// slot counter, operator outer loop
//****************************************
`timescale 1ns/1ns

module fm_slot_seq (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    output logic [fm_pkg::ch_w-1:0] ch,   // next slot's channel
    output logic [fm_pkg::op_w-1:0] op,   // next slot's operator
    output logic                    slot_ok
);
    import fm_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ch      <= '0;
            op      <= '0;
            slot_ok <= 1'b0;
        end else if (cen) begin
            slot_ok <= 1'b1;                 // first enable names a real slot
            if (ch == ch_w'(num_ch - 1)) begin
                ch <= '0;
                op <= op + 1'b1;             // wraps after the last operator
            end else begin
                ch <= ch + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) ch < num_ch);

endmodule

//--- logic/fm_ch_regs.sv
//****************************************
// channel register file, slot-ordered
// output and packed readback word
//****************************************
`timescale 1ns/1ns

module fm_ch_regs (
    input  logic                             rst,
    input  logic                             clk,
    input  logic                             cen,
    input  logic [7:0]                       din,
    input  logic [fm_pkg::ch_w-1:0]          up_ch,
    input  logic [5:0]                       latch_fnum,
    input  logic                             up_fnumlo,
    input  logic                             up_alg,
    input  logic                             up_pms,
    input  logic [fm_pkg::ch_w-1:0]          ch,     // channel of the next slot
    input  logic [fm_pkg::ch_w-1:0]          rd_ch,
    output logic [fm_pkg::block_w-1:0]       block,
    output logic [fm_pkg::fnum_w-1:0]        fnum,
    output logic [2:0]                       fb,
    output logic [2:0]                       alg,
    output logic [1:0]                       rl,
    output logic [1:0]                       ams,
    output logic [2:0]                       pms,
    output logic [fm_pkg::axi_data_w-1:0]    rd_word
);
    import fm_pkg::*;

    // plain registers, a write lands on the very next clock
    logic [block_w-1:0] r_block [num_ch];
    logic [fnum_w-1:0]  r_fnum  [num_ch];
    logic [2:0]         r_fb    [num_ch];
    logic [2:0]         r_alg   [num_ch];
    logic [1:0]         r_rl    [num_ch];
    logic [1:0]         r_ams   [num_ch];
    logic [2:0]         r_pms   [num_ch];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_ch; i++) begin
                r_block[i] <= '0;
                r_fnum[i]  <= '0;
                r_fb[i]    <= '0;
                r_alg[i]   <= '0;
                r_rl[i]    <= 2'd3;  // both speakers on
                r_ams[i]   <= '0;
                r_pms[i]   <= '0;
            end
        end else begin
            if (up_fnumlo)
                {r_block[up_ch], r_fnum[up_ch]} <= {latch_fnum, din};
            if (up_alg) begin
                r_fb[up_ch]  <= din[5:3];
                r_alg[up_ch] <= din[2:0];
            end
            if (up_pms) begin
                r_rl[up_ch]  <= din[7:6];
                r_ams[up_ch] <= din[5:4];
                r_pms[up_ch] <= din[2:0];
            end
        end
    end

    // fields of the named channel, one enable later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            block <= '0;
            fnum  <= '0;
            fb    <= '0;
            alg   <= '0;
            rl    <= 2'd3;
            ams   <= '0;
            pms   <= '0;
        end else if (cen) begin
            block <= r_block[ch];
            fnum  <= r_fnum[ch];
            fb    <= r_fb[ch];
            alg   <= r_alg[ch];
            rl    <= r_rl[ch];
            ams   <= r_ams[ch];
            pms   <= r_pms[ch];
        end
    end

    // packed from bit 0 up: pms ams rl alg fb fnum block
    assign rd_word = axi_data_w'({r_block[rd_ch], r_fnum[rd_ch], r_fb[rd_ch],
                                  r_alg[rd_ch], r_rl[rd_ch], r_ams[rd_ch], r_pms[rd_ch]});

endmodule

//--- logic/fm_op_regs.sv
//****************************************
// operator register file, 24 slots
// read in slot order
//****************************************
`timescale 1ns/1ns

module fm_op_regs (
    input  logic                       rst,
    input  logic                       clk,
    input  logic                       cen,
    input  logic [7:0]                 din,
    input  logic [fm_pkg::ch_w-1:0]    up_op_ch,
    input  logic [fm_pkg::op_w-1:0]    up_op,
    input  logic                       up_mul,
    input  logic                       up_tl,
    input  logic [fm_pkg::ch_w-1:0]    ch,      // next slot
    input  logic [fm_pkg::op_w-1:0]    op,
    output logic [fm_pkg::mul_w-1:0]   mul,
    output logic [fm_pkg::tl_w-1:0]    tl
);
    import fm_pkg::*;

    logic [mul_w-1:0]  r_mul [num_slot];
    logic [tl_w-1:0]   r_tl  [num_slot];
    logic [slot_w-1:0] wr_slot;
    logic [slot_w-1:0] rd_slot;

    // slot number = op*6 + ch, same order the sequencer walks
    assign wr_slot = slot_w'(up_op) * slot_w'(num_ch) + slot_w'(up_op_ch);
    assign rd_slot = slot_w'(op) * slot_w'(num_ch) + slot_w'(ch);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_slot; i++) begin
                r_mul[i] <= '0;
                r_tl[i]  <= '0;
            end
        end else begin
            if (up_mul)
                r_mul[wr_slot] <= din[mul_w-1:0];
            if (up_tl)
                r_tl[wr_slot] <= din[tl_w-1:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mul <= '0;
            tl  <= '0;
        end else if (cen) begin
            mul <= r_mul[rd_slot];  // aligned with the channel bank output
            tl  <= r_tl[rd_slot];
        end
    end

endmodule

//--- logic/fm_phase_step.sv
//****************************************
// phase increment from fnum, block, mul
// plus the fields kept in step with it
//****************************************
`timescale 1ns/1ns

module fm_phase_step (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cen,
    input  logic                        in_valid,
    input  logic [fm_pkg::ch_w-1:0]     in_ch,
    input  logic [fm_pkg::op_w-1:0]     in_op,
    input  logic [fm_pkg::fnum_w-1:0]   fnum,
    input  logic [fm_pkg::block_w-1:0]  block,
    input  logic [fm_pkg::mul_w-1:0]    mul,
    input  logic [2:0]                  alg_in,
    input  logic [2:0]                  fb_in,
    input  logic [1:0]                  rl_in,
    input  logic [fm_pkg::tl_w-1:0]     tl_in,
    output logic                        out_valid,
    output logic [fm_pkg::ch_w-1:0]     out_ch,
    output logic [fm_pkg::op_w-1:0]     out_op,
    output logic [fm_pkg::phase_w-1:0]  phase_inc,
    output logic [2:0]                  alg,
    output logic [2:0]                  fb,
    output logic [1:0]                  rl,
    output logic [fm_pkg::tl_w-1:0]     tl
);
    import fm_pkg::*;

    logic [fnum_w+6:0]  fshift;   // room for block up to 7
    logic [fnum_w+5:0]  base;     // shifted fnum halved once
    logic [phase_w-1:0] inc_next;

    assign fshift   = {7'd0, fnum} << block;
    assign base     = fshift[fnum_w+6:1];
    // mul of zero means one half
    assign inc_next = (mul == '0) ? phase_w'(base >> 1)
                                  : phase_w'(base) * phase_w'(mul);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_ch    <= '0;
            out_op    <= '0;
            phase_inc <= '0;
            alg       <= '0;
            fb        <= '0;
            rl        <= 2'd3;
            tl        <= '0;
        end else if (cen) begin
            out_valid <= in_valid;
            out_ch    <= in_ch;
            out_op    <= in_op;
            phase_inc <= inc_next;
            alg       <= alg_in;   // delayed with phase_inc
            fb        <= fb_in;
            rl        <= rl_in;
            tl        <= tl_in;
        end
    end

endmodule

//--- logic/fm_regs_top.sv
//****************************************
// fm register side top level
//****************************************
`timescale 1ns/1ns

module fm_regs_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cen,
    input  logic [fm_pkg::axi_addr_w-1:0] awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [fm_pkg::axi_data_w-1:0] wdata,
    input  logic [3:0]                    wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [fm_pkg::axi_addr_w-1:0] araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [fm_pkg::axi_data_w-1:0] rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,
    output logic                          out_valid,
    output logic [fm_pkg::ch_w-1:0]       out_ch,
    output logic [fm_pkg::op_w-1:0]       out_op,
    output logic [fm_pkg::phase_w-1:0]    phase_inc,
    output logic [2:0]                    alg,
    output logic [2:0]                    fb,
    output logic [1:0]                    rl,
    output logic [fm_pkg::tl_w-1:0]       tl
);
    import fm_pkg::*;

    // host side
    logic                  wr_stb;
    logic [8:0]            wr_addr;
    logic [7:0]            wr_data;
    logic [ch_w-1:0]       rd_ch;
    logic [axi_data_w-1:0] rd_word;
    // decoder strobes
    logic [7:0]            din;
    logic [ch_w-1:0]       up_ch, up_op_ch;
    logic [op_w-1:0]       up_op;
    logic [5:0]            latch_fnum;
    logic                  up_fnumlo, up_alg, up_pms, up_mul, up_tl;
    // slot pipeline
    logic [ch_w-1:0]       seq_ch, seq_ch_d;
    logic [op_w-1:0]       seq_op, seq_op_d;
    logic                  seq_ok, seq_ok_d;
    logic [block_w-1:0]    bk_block;
    logic [fnum_w-1:0]     bk_fnum;
    logic [2:0]            bk_fb, bk_alg;
    logic [1:0]            bk_rl;
    logic [mul_w-1:0]      op_mul;
    logic [tl_w-1:0]       op_tl;

    fm_host_port u_host (.*);

    fm_reg_decode u_dec (.*);

    fm_slot_seq u_seq (.clk, .rst, .cen, .ch(seq_ch), .op(seq_op), .slot_ok(seq_ok));

    // slot index one enable behind the sequencer, level with the banks
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seq_ch_d <= '0;
            seq_op_d <= '0;
            seq_ok_d <= 1'b0;
        end else if (cen) begin
            seq_ch_d <= seq_ch;
            seq_op_d <= seq_op;
            seq_ok_d <= seq_ok;
        end
    end

    fm_ch_regs u_ch (
        .rst, .clk, .cen, .din, .up_ch, .latch_fnum, .up_fnumlo, .up_alg, .up_pms,
        .ch(seq_ch), .rd_ch, .block(bk_block), .fnum(bk_fnum), .fb(bk_fb),
        .alg(bk_alg), .rl(bk_rl), .ams(), .pms(), .rd_word
    );

    fm_op_regs u_op (
        .rst, .clk, .cen, .din, .up_op_ch, .up_op, .up_mul, .up_tl,
        .ch(seq_ch), .op(seq_op), .mul(op_mul), .tl(op_tl)
    );

    fm_phase_step u_step (
        .clk, .rst, .cen, .in_valid(seq_ok_d), .in_ch(seq_ch_d), .in_op(seq_op_d),
        .fnum(bk_fnum), .block(bk_block), .mul(op_mul), .alg_in(bk_alg),
        .fb_in(bk_fb), .rl_in(bk_rl), .tl_in(op_tl), .out_valid, .out_ch, .out_op,
        .phase_inc, .alg, .fb, .rl, .tl
    );

endmodule

//--- tests/fm_axil_tasks.svh
//****************************************
// axi4-lite write and read sequences
// and the value compare used by all checks
//****************************************
`ifndef FM_AXIL_TASKS_SVH
`define FM_AXIL_TASKS_SVH

task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
    end
endtask

// called on a falling edge, address and data go out together
task automatic start_write(input logic [9:0] a, input logic [7:0] d, input logic [3:0] s);
    awaddr  = a;
    wdata   = {24'hc3c3c3, d};  // upper lanes carry junk
    wstrb   = s;
    awvalid = 1'b1;
    wvalid  = 1'b1;
endtask

task automatic finish_write();
    do @(posedge clk); while (!awready);
    compare(wready, 1'b1, "wready low while awready high");  // both channels taken together
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
endtask

task automatic collect_bresp();
    bready = 1'b1;
    do @(posedge clk); while (!bvalid);
    compare(bresp, 2'b00, "write response not OKAY");
    @(negedge clk);
    bready = 1'b0;
endtask

task automatic read_word(input logic [9:0] a, output logic [31:0] w);
    araddr  = a;
    arvalid = 1'b1;
    rready  = 1'b1;
    do @(posedge clk); while (!arready);
    @(negedge clk);
    arvalid = 1'b0;
    do @(posedge clk); while (!rvalid);  // data sits one cycle behind the address
    w = rdata;
    compare(rresp, 2'b00, "read response not OKAY");
    @(negedge clk);
    rready = 1'b0;
endtask

`endif

//--- tests/fm_regs_tb.sv
//****************************************
// testbench for fm_regs_top, register
// table, shadow model and slot checker
//****************************************
`timescale 1ns/1ns

module fm_regs_tb;
    import fm_pkg::*;

    localparam int rst_cycles = 16;
    localparam int max_gap    = 4;   // cen is forced high after three low cycles
    localparam int n_rows     = 21;
    localparam int limit      = rst_cycles + n_rows * 10 * max_gap + 4 * num_slot * max_gap;

    logic clk, rst, cen;
    logic [axi_addr_w-1:0] awaddr, araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [axi_data_w-1:0] wdata, rdata;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;
    logic out_valid;
    logic [ch_w-1:0] out_ch;
    logic [op_w-1:0] out_op;
    logic [phase_w-1:0] phase_inc;
    logic [2:0] alg, fb;
    logic [1:0] rl;
    logic [tl_w-1:0] tl;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    integer seed = 32'h3685071f;
    integer rnd;
    int gap = 0;
    logic checking = 1'b0;  // slot fields compared only while the model is settled
    logic seen = 1'b0;
    int last_slot, slot, r, n, k;
    logic [31:0] word;

    // stimulus table
    logic [9:0]  t_addr [n_rows];
    logic [7:0]  t_data [n_rows];
    logic [3:0]  t_strb [n_rows];
    int          t_hold [n_rows];  // nonzero holds bready, next row waits meanwhile
    logic [9:0]  t_rd   [n_rows];
    logic [31:0] t_exp  [n_rows];
    int n_used = 0;

    // shadow model
    logic [2:0]  m_block [num_ch];
    logic [10:0] m_fnum  [num_ch];
    logic [2:0]  m_fb    [num_ch];
    logic [2:0]  m_alg   [num_ch];
    logic [1:0]  m_rl    [num_ch];
    logic [3:0]  m_mul   [num_slot];
    logic [6:0]  m_tl    [num_slot];
    logic [5:0]  m_latch;

    `include "fm_axil_tasks.svh"

    fm_regs_top dut0 (.*);

    always #20 clk = ~clk;

    // irregular clock enable
    always @(negedge clk) begin
        rnd = $random(seed);
        cen = rnd[0] || gap >= max_gap - 1;
        gap = cen ? 0 : gap + 1;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic int phase_of(logic [10:0] f, logic [2:0] b, logic [3:0] m);
        int s;
        s = (int'(f) << b) >> 1;
        return (m == 0) ? s >> 1 : s * m;  // multiplier zero counts as one half
    endfunction

    task automatic check_slot(input int c, input int o);
        compare(phase_inc, phase_of(m_fnum[c], m_block[c], m_mul[o * num_ch + c]),
                $sformatf("phase_inc ch%0d op%0d", c, o));
        compare(alg, m_alg[c], $sformatf("alg ch%0d op%0d", c, o));
        compare(fb, m_fb[c], $sformatf("fb ch%0d op%0d", c, o));
        compare(rl, m_rl[c], $sformatf("rl ch%0d op%0d", c, o));
        compare(tl, m_tl[o * num_ch + c], $sformatf("tl ch%0d op%0d", c, o));
    endtask

    // every enabled edge after the first valid one must carry the next slot
    always @(posedge clk) begin
        if (!rst && cen) begin
            if (seen)
                compare(out_valid, 1'b1, "out_valid dropped");
            if (out_valid) begin
                slot = out_op * num_ch + out_ch;
                compare(out_ch < num_ch, 1'b1, "out_ch out of range");
                if (seen)
                    compare(slot, (last_slot + 1) % num_slot, "slot order");
                last_slot = slot;
                seen      = 1'b1;
                if (checking && out_ch < num_ch)
                    check_slot(out_ch, out_op);
            end
        end
    end

    task automatic reset_model();
        for (int i = 0; i < num_ch; i++) begin
            m_block[i] = '0;
            m_fnum[i]  = '0;
            m_fb[i]    = '0;
            m_alg[i]   = '0;
            m_rl[i]    = 2'd3;
        end
        for (int i = 0; i < num_slot; i++) begin
            m_mul[i] = '0;
            m_tl[i]  = '0;
        end
        m_latch = '0;
    endtask

    task automatic apply_write(input logic [9:0] a, input logic [7:0] d, input logic [3:0] s);
        logic [7:0] rn;
        int c;
        int sl;
        rn = a[7:0];
        c  = rn[1:0] + (a[8] ? 3 : 0);   // part bit adds three channels
        sl = rn[3:2] * num_ch + c;
        if (s[0] && !a[9] && rn[1:0] != 2'd3) begin
            if (rn[7:4] == reg_mul[7:4])
                m_mul[sl] = d[3:0];
            else if (rn[7:4] == reg_tl[7:4])
                m_tl[sl] = d[6:0];
            else if (rn[7:2] == reg_fnum_lo[7:2]) begin
                m_block[c] = m_latch[5:3];
                m_fnum[c]  = {m_latch[2:0], d};
            end else if (rn[7:2] == reg_fnum_hi[7:2])
                m_latch = d[5:0];
            else if (rn[7:2] == reg_fb_alg[7:2]) begin
                m_fb[c]  = d[5:3];
                m_alg[c] = d[2:0];
            end else if (rn[7:2] == reg_pan_pms[7:2])
                m_rl[c] = d[7:6];
        end
    endtask

    task automatic add_row(input logic [9:0] a, input logic [7:0] d, input logic [3:0] s,
                           input int h, input logic [9:0] ra, input logic [31:0] e);
        t_addr[n_used] = a;
        t_data[n_used] = d;
        t_strb[n_used] = s;
        t_hold[n_used] = h;
        t_rd[n_used]   = ra;
        t_exp[n_used]  = e;
        n_used++;
    endtask

    task automatic wait_enables(input int cnt);
        int seen_en;
        seen_en = 0;
        while (seen_en < cnt) begin
            @(posedge clk);
            if (cen)
                seen_en++;
        end
    endtask

    // lets the bank update and the pipeline drain before slots are compared again
    task automatic settle();
        repeat (2) @(posedge clk);
        wait_enables(3);
        @(negedge clk);
        checking = 1'b1;
    endtask

    initial begin
        clk     = 0;
        rst     = 1;
        cen     = 0;
        awaddr  = '0;
        awvalid = 0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 0;
        bready  = 0;
        araddr  = '0;
        arvalid = 0;
        rready  = 0;
        reset_model();
        // addr, byte, strobes, hold, readback address, expected readback
        add_row(10'h0A4, 8'h22, 4'hF, 0, 10'h200, 32'h00000060);  // high byte only
        add_row(10'h0A0, 8'h34, 4'hF, 0, 10'h200, 32'h04468060);  // commit ch0
        add_row(10'h0A5, 8'h1D, 4'hF, 0, 10'h204, 32'h00000060);
        add_row(10'h1A2, 8'h80, 4'hF, 0, 10'h214, 32'h03B00060);  // ch5 takes ch1 latch
        add_row(10'h030, 8'h03, 4'hF, 0, 10'h200, 32'h04468060);
        add_row(10'h038, 8'h0F, 4'hF, 0, 10'h200, 32'h04468060);
        add_row(10'h04C, 8'h7F, 4'hF, 0, 10'h200, 32'h04468060);
        add_row(10'h13E, 8'h07, 4'hF, 0, 10'h214, 32'h03B00060);
        add_row(10'h145, 8'h2A, 4'hF, 0, 10'h210, 32'h00000060);
        add_row(10'h039, 8'hF2, 4'hF, 0, 10'h204, 32'h00000060);  // upper bits dropped
        add_row(10'h0B0, 8'h2D, 4'hF, 0, 10'h200, 32'h044696E0);
        add_row(10'h1B5, 8'h96, 4'hF, 0, 10'h210, 32'h0000004E);
        add_row(10'h0B6, 8'h40, 4'hF, 0, 10'h208, 32'h00000020);
        add_row(10'h1B0, 8'h3F, 4'hF, 0, 10'h20C, 32'h00001FE0);
        add_row(10'h0B0, 8'h00, 4'hE, 0, 10'h200, 32'h044696E0);  // lane 0 off
        add_row(10'h0B3, 8'h00, 4'hF, 0, 10'h20C, 32'h00001FE0);  // channel field 3
        add_row(10'h050, 8'hFF, 4'hF, 0, 10'h218, 32'h00000000);  // unmapped, past window
        add_row(10'h2B0, 8'h00, 4'hF, 0, 10'h100, 32'h00000000);
        add_row(10'h135, 8'h05, 4'hF, 6, 10'h20C, 32'h00001FE0);  // response held
        add_row(10'h041, 8'h55, 4'hF, 0, 10'h204, 32'h00000060);
        add_row(10'h1A1, 8'hFF, 4'hF, 0, 10'h210, 32'h03BFE04E);  // latch kept

        repeat (rst_cycles) @(negedge clk);
        rst = 0;
        checking = 1'b1;
        for (k = 0; k < num_ch; k++) begin
            read_word(rd_base + 4 * k, word);
            compare(word, 32'h00000060, $sformatf("reset readback ch%0d", k));
        end
        wait_enables(num_slot + 3);
        compare(seen, 1'b1, "out_valid never went high");

        r = 0;
        while (r < n_used) begin
            @(negedge clk);
            checking = 1'b0;
            start_write(t_addr[r], t_data[r], t_strb[r]);
            finish_write();
            n = 1;
            if (t_hold[r] != 0 && r + 1 < n_used) begin
                start_write(t_addr[r + 1], t_data[r + 1], t_strb[r + 1]);
                repeat (t_hold[r]) begin
                    @(posedge clk);
                    compare(awready, 1'b0, "write accepted while response pending");
                    compare(bvalid, 1'b1, "held write response lost");
                end
                @(negedge clk);
                collect_bresp();
                finish_write();
                n = 2;
            end
            collect_bresp();
            for (k = r; k < r + n; k++)
                apply_write(t_addr[k], t_data[k], t_strb[k]);
            settle();
            for (k = r; k < r + n; k++) begin
                read_word(t_rd[k], word);
                compare(word, t_exp[k], $sformatf("readback row %0d", k));
            end
            r += n;
        end

        wait_enables(2 * num_slot);  // every slot against the final model
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+tests
logic/fm_pkg.sv
logic/fm_host_port.sv
logic/fm_reg_decode.sv
logic/fm_slot_seq.sv
logic/fm_ch_regs.sv
logic/fm_op_regs.sv
logic/fm_phase_step.sv
logic/fm_regs_top.sv
tests/fm_regs_tb.sv
